// File: logic/io_pkg.sv
package io_pkg;

    ////////////////////////////////
    // Widths
    ////////////////////////////////

    // Port bus byte width
    localparam int DATA_W = 8;

    // One decimal digit
    localparam int BCD_W = 4;

    // Digits on the board display
    localparam int DIGITS = 4;

    // Seven segments plus decimal point
    localparam int SEG_W = 8;

    // Refresh prescaler width, 16 cycles per digit here
    // A board build wants something near 17 for a visible refresh
    localparam int SCAN_BITS = 4;

    ////////////////////////////////
    // Types
    ////////////////////////////////

    typedef logic [DATA_W-1:0] port_id_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BCD_W-1:0] bcd_t;

    // Active low, one bit per digit
    typedef logic [DIGITS-1:0] anode_t;

    // Active low, bit 7 is dp, bits 6..0 are g..a
    typedef logic [SEG_W-1:0] cathode_t;

    // Index of the digit being scanned
    typedef logic [$clog2(DIGITS)-1:0] digit_sel_t;

    ////////////////////////////////
    // Port map
    ////////////////////////////////

    // Input ports
    localparam port_id_t SWITCHES_ID = 8'h20;

    // Output ports
    localparam port_id_t LEDS_ID = 8'h40;
    localparam port_id_t SEG_ID  = 8'h41;

    // All segments and dp dark
    localparam cathode_t SEG_BLANK = 8'hFF;

endpackage

// File: logic/io_port_decoder.sv
`timescale 1ns/1ps

module io_port_decoder (
    input  logic             CLK,
    input  logic             rst_n,
    input  io_pkg::port_id_t port_id,
    input  io_pkg::data_t    out_port,
    input  logic             io_strb,
    input  io_pkg::data_t    switches,
    output io_pkg::data_t    in_port,
    output io_pkg::data_t    leds,
    output io_pkg::data_t    seg_value
);

    ////////////////////////////////
    // Input side
    ////////////////////////////////

    // Switches are the only readable port for now
    // Any other id reads back as zero
    always_comb begin
        if (port_id == io_pkg::SWITCHES_ID) begin
            in_port = switches;
        end else begin
            in_port = '0;
        end
    end

    ////////////////////////////////
    // Output side
    ////////////////////////////////

    // Held output registers
    io_pkg::data_t led_reg;
    io_pkg::data_t seg_reg;

    // Write decode, one strobe per write
    logic led_wr;
    logic seg_wr;

    assign led_wr = io_strb && (port_id == io_pkg::LEDS_ID);
    assign seg_wr = io_strb && (port_id == io_pkg::SEG_ID);

    // LED register
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            led_reg <= '0;
        end else if (led_wr) begin
            led_reg <= out_port;
        end
    end

    // Display register, shown in decimal by the scanner
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            seg_reg <= '0;
        end else if (seg_wr) begin
            seg_reg <= out_port;
        end
    end

    // Unknown ids and idle cycles fall through, registers hold

    assign leds      = led_reg;
    assign seg_value = seg_reg;

endmodule

// File: logic/bin_to_bcd.sv
`timescale 1ns/1ps

module bin_to_bcd (
    input  io_pkg::data_t value,
    output io_pkg::bcd_t  hundreds,
    output io_pkg::bcd_t  tens,
    output io_pkg::bcd_t  ones
);

    ////////////////////////////////
    // Layout of the working register
    ////////////////////////////////

    // Three BCD columns above the binary byte
    localparam int BCD_COLS = 3;
    localparam int WORK_W   = BCD_COLS * io_pkg::BCD_W + io_pkg::DATA_W;

    // Column base bits inside the working register
    localparam int ONES_LSB = io_pkg::DATA_W;
    localparam int TENS_LSB = ONES_LSB + io_pkg::BCD_W;
    localparam int HUND_LSB = TENS_LSB + io_pkg::BCD_W;

    logic [WORK_W-1:0] work;

    ////////////////////////////////
    // Shift and add three
    ////////////////////////////////

    // One pass per input bit, MSB first
    // Before each shift, a ones or tens column of 5 or more gets 3 added
    // so that the shift carries it into the next decade
    // Hundreds never passes 2 for a byte
    always_comb begin
        work = {{(WORK_W - io_pkg::DATA_W){1'b0}}, value};
        for (int i = 0; i < io_pkg::DATA_W; i++) begin
            // Ones column
            if (work[ONES_LSB +: io_pkg::BCD_W] > io_pkg::bcd_t'(4)) begin
                work[ONES_LSB +: io_pkg::BCD_W] =
                    work[ONES_LSB +: io_pkg::BCD_W] + io_pkg::bcd_t'(3);
            end
            // Tens column
            if (work[TENS_LSB +: io_pkg::BCD_W] > io_pkg::bcd_t'(4)) begin
                work[TENS_LSB +: io_pkg::BCD_W] =
                    work[TENS_LSB +: io_pkg::BCD_W] + io_pkg::bcd_t'(3);
            end
            work = work << 1;
        end
    end

    ////////////////////////////////
    // Digit outputs
    ////////////////////////////////

    // Binary part has shifted out, columns now hold the digits
    assign ones     = work[ONES_LSB +: io_pkg::BCD_W];
    assign tens     = work[TENS_LSB +: io_pkg::BCD_W];
    assign hundreds = work[HUND_LSB +: io_pkg::BCD_W];

endmodule

// File: logic/seg_scanner.sv
`timescale 1ns/1ps

module seg_scanner (
    input  logic                CLK,
    input  logic                rst_n,
    input  io_pkg::bcd_t        hundreds,
    input  io_pkg::bcd_t        tens,
    input  io_pkg::bcd_t        ones,
    output io_pkg::anode_t      anodes,
    output io_pkg::cathode_t    cathodes
);

    ////////////////////////////////
    // Segment table
    ////////////////////////////////

    // Common anode, so a 0 lights the segment
    // Bit 7 is dp and stays dark
    function automatic io_pkg::cathode_t seg_decode(input io_pkg::bcd_t digit);
        io_pkg::cathode_t pattern;
        case (digit)
            4'd0:    pattern = 8'hC0;
            4'd1:    pattern = 8'hF9;
            4'd2:    pattern = 8'hA4;
            4'd3:    pattern = 8'hB0;
            4'd4:    pattern = 8'h99;
            4'd5:    pattern = 8'h92;
            4'd6:    pattern = 8'h82;
            4'd7:    pattern = 8'hF8;
            4'd8:    pattern = 8'h80;
            4'd9:    pattern = 8'h90;
            // Codes above 9 never come out of the converter
            default: pattern = io_pkg::SEG_BLANK;
        endcase
        return pattern;
    endfunction

    ////////////////////////////////
    // Refresh prescaler
    ////////////////////////////////

    logic [io_pkg::SCAN_BITS-1:0] prescale;
    logic                         scan_tick;

    // Free running, counts every cycle from zero
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // High on the last count before the wrap
    assign scan_tick = &prescale;

    ////////////////////////////////
    // Digit rotation
    ////////////////////////////////

    io_pkg::digit_sel_t digit_sel;

    // Advances on the wrap edge, 3 rolls over to 0
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            digit_sel <= '0;
        end else if (scan_tick) begin
            digit_sel <= digit_sel + 1'b1;
        end
    end

    ////////////////////////////////
    // Slot select and blanking
    ////////////////////////////////

    io_pkg::bcd_t slot_digit;
    logic         slot_lit;

    // Slot 0 ones, 1 tens, 2 hundreds, 3 unused
    // Leading zeros go dark, ones always shows
    always_comb begin
        slot_digit = ones;
        slot_lit   = 1'b0;
        case (digit_sel)
            2'd0: begin
                slot_digit = ones;
                slot_lit   = 1'b1;
            end
            2'd1: begin
                slot_digit = tens;
                slot_lit   = (hundreds != '0) || (tens != '0);
            end
            2'd2: begin
                slot_digit = hundreds;
                slot_lit   = (hundreds != '0);
            end
            default: begin
                // Fourth digit stays dark
                slot_digit = ones;
                slot_lit   = 1'b0;
            end
        endcase
    end

    ////////////////////////////////
    // Display drive
    ////////////////////////////////

    // Lit slot pulls exactly its own anode low
    // Dark slot turns every anode off
    always_comb begin
        if (slot_lit) begin
            anodes   = ~(io_pkg::anode_t'(1) << digit_sel);
            cathodes = seg_decode(slot_digit);
        end else begin
            anodes   = '1;
            cathodes = io_pkg::SEG_BLANK;
        end
    end

endmodule

// File: logic/io_wrapper.sv
`timescale 1ns/1ps

module io_wrapper (
    input  logic             CLK,
    input  logic             rst_n,
    // Board switches
    input  io_pkg::data_t    switches,
    // Port bus from the processor
    input  io_pkg::port_id_t port_id,
    input  io_pkg::data_t    out_port,
    input  logic             io_strb,
    output io_pkg::data_t    in_port,
    // Board outputs
    output io_pkg::data_t    leds,
    output io_pkg::anode_t   anodes,
    output io_pkg::cathode_t cathodes
);

    ////////////////////////////////
    // Internal wires
    ////////////////////////////////

    // Display register value
    io_pkg::data_t seg_value;

    // Decimal digits of the display value
    io_pkg::bcd_t hundreds;
    io_pkg::bcd_t tens;
    io_pkg::bcd_t ones;

    ////////////////////////////////
    // Port bus decode
    ////////////////////////////////

    io_port_decoder u_decoder (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .port_id   (port_id),
        .out_port  (out_port),
        .io_strb   (io_strb),
        .switches  (switches),
        .in_port   (in_port),
        .leds      (leds),
        .seg_value (seg_value)
    );

    ////////////////////////////////
    // Binary to decimal
    ////////////////////////////////

    bin_to_bcd u_bcd (
        .value    (seg_value),
        .hundreds (hundreds),
        .tens     (tens),
        .ones     (ones)
    );

    ////////////////////////////////
    // Seven segment scan
    ////////////////////////////////

    seg_scanner u_scanner (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .hundreds (hundreds),
        .tens     (tens),
        .ones     (ones),
        .anodes   (anodes),
        .cathodes (cathodes)
    );

endmodule

// File: test/io_wrapper_checker.sv
`timescale 1ns/1ps

module io_wrapper_checker (
    input  logic             CLK,
    input  logic             rst_n,
    input  io_pkg::port_id_t port_id,
    input  io_pkg::data_t    out_port,
    input  logic             io_strb,
    input  io_pkg::data_t    leds,
    input  io_pkg::anode_t   anodes,
    input  io_pkg::cathode_t cathodes
);

    // Failed assertions so far, read by the testbench at the end
    int unsigned fail_count;

    initial fail_count = 0;

    //////////////////////////////
    // Display drive
    //////////////////////////////

    // Never two digits lit at once
    a_one_anode: assert property (@(posedge CLK) disable iff (!rst_n)
        $onehot0(~anodes))
    else begin
        fail_count = fail_count + 1;
        $error("more than one anode driven low");
    end

    // Dark slot means dark segments
    a_blank_slot: assert property (@(posedge CLK) disable iff (!rst_n)
        (&anodes) |-> (cathodes == io_pkg::SEG_BLANK))
    else begin
        fail_count = fail_count + 1;
        $error("segments lit while every anode is off");
    end

    //////////////////////////////
    // LED register
    //////////////////////////////

    // Strobed write lands on the LEDs one cycle later
    a_led_write: assert property (@(posedge CLK) disable iff (!rst_n)
        (io_strb && (port_id == io_pkg::LEDS_ID)) |=> (leds == $past(out_port)))
    else begin
        fail_count = fail_count + 1;
        $error("LED register did not take the strobed byte");
    end

endmodule

bind io_wrapper io_wrapper_checker u_checker (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .port_id  (port_id),
    .out_port (out_port),
    .io_strb  (io_strb),
    .leds     (leds),
    .anodes   (anodes),
    .cathodes (cathodes)
);

// File: test/io_wrapper_tb.sv
`timescale 1ns/1ps

module io_wrapper_tb;

    //////////////////////////////
    // Run length
    //////////////////////////////

    localparam int RESET_CYCLES   = 16;
    localparam int STIM_CYCLES    = 4000;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

    // Cycles each digit stays lit
    localparam int SLOT_CYCLES = 1 << io_pkg::SCAN_BITS;

    // Common anode patterns for 0..9, dp dark
    localparam io_pkg::cathode_t DIGIT_SEGS [0:9] = '{
        8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99,
        8'h92, 8'h82, 8'hF8, 8'h80, 8'h90
    };

    // DUT pins
    logic             CLK;
    logic             rst_n;
    io_pkg::data_t    switches;
    io_pkg::port_id_t port_id;
    io_pkg::data_t    out_port;
    logic             io_strb;
    io_pkg::data_t    in_port;
    io_pkg::data_t    leds;
    io_pkg::anode_t   anodes;
    io_pkg::cathode_t cathodes;

    // Reference model state
    io_pkg::data_t model_leds;
    io_pkg::data_t model_seg;
    int unsigned   scan_cnt;

    logic [31:0] lcg_state;
    int unsigned cycle_count;

    io_wrapper dut (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .switches (switches),
        .port_id  (port_id),
        .out_port (out_port),
        .io_strb  (io_strb),
        .in_port  (in_port),
        .leds     (leds),
        .anodes   (anodes),
        .cathodes (cathodes)
    );

    //////////////////////////////
    // Clock and timeout
    //////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Numerical Recipes LCG
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // About 5/16 of cycles on each known port, the rest anywhere
    task automatic drive_random();
        logic [31:0] r;
        logic [31:0] d;
        r = next_rand();
        d = next_rand();
        if (r[31:28] < 4'd5) begin
            port_id <= io_pkg::SWITCHES_ID;
        end else if (r[31:28] < 4'd10) begin
            port_id <= io_pkg::LEDS_ID;
        end else if (r[31:28] < 4'd15) begin
            port_id <= io_pkg::SEG_ID;
        end else begin
            port_id <= d[15:8];
        end
        io_strb  <= r[27];
        out_port <= d[31:24];
        switches <= d[23:16];
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Called right after a rising edge, before new inputs settle
    task automatic update_model();
        if (rst_n) begin
            if (io_strb && (port_id == io_pkg::LEDS_ID)) begin
                model_leds = out_port;
            end
            if (io_strb && (port_id == io_pkg::SEG_ID)) begin
                model_seg = out_port;
            end
            scan_cnt = scan_cnt + 1;
        end
    endtask

    // Slot 0 ones, 1 tens, 2 hundreds, 3 dark
    task automatic expected_display(input io_pkg::data_t value, input int slot,
                                    output io_pkg::anode_t an,
                                    output io_pkg::cathode_t ca);
        int digit;
        bit lit;
        digit = 0;
        lit   = 1'b0;
        case (slot)
            0: begin
                digit = value % 10;
                lit   = 1'b1;
            end
            1: begin
                digit = (value / 10) % 10;
                lit   = (value >= 10);
            end
            2: begin
                digit = value / 100;
                lit   = (value >= 100);
            end
            default: lit = 1'b0;
        endcase
        if (lit) begin
            an = 4'b1111;
            an[slot] = 1'b0;
            ca = DIGIT_SEGS[digit];
        end else begin
            an = 4'b1111;
            ca = io_pkg::SEG_BLANK;
        end
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_data(input string what, input io_pkg::data_t got,
                              input io_pkg::data_t exp);
        if (got !== exp) begin
            $display("error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_anode(input io_pkg::anode_t got, input io_pkg::anode_t exp);
        if (got !== exp) begin
            $display("error: %0t ns: anodes is %b, expected %b", $time, got, exp);
            $display("sim failed");
            $fatal(1, "anode mismatch");
        end
    endtask

    task automatic check_cathode(input io_pkg::cathode_t got, input io_pkg::cathode_t exp);
        if (got !== exp) begin
            $display("error: %0t ns: cathodes is %h, expected %h", $time, got, exp);
            $display("sim failed");
            $fatal(1, "cathode mismatch");
        end
    endtask

    // Sampled on the falling edge, all outputs settled
    task automatic check_outputs();
        io_pkg::data_t    exp_in;
        io_pkg::anode_t   exp_an;
        io_pkg::cathode_t exp_ca;
        int               slot;
        exp_in = (port_id == io_pkg::SWITCHES_ID) ? switches : 8'h00;
        slot   = (scan_cnt / SLOT_CYCLES) % 4;
        expected_display(model_seg, slot, exp_an, exp_ca);
        check_data("in_port", in_port, exp_in);
        check_data("leds", leds, model_leds);
        check_anode(anodes, exp_an);
        check_cathode(cathodes, exp_ca);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n       = 1'b0;
        switches    = '0;
        port_id     = '0;
        out_port    = '0;
        io_strb     = 1'b0;
        model_leds  = '0;
        model_seg   = '0;
        scan_cnt    = 0;
        lcg_state   = 32'h39488685;
        cycle_count = 0;

        for (int i = 0; i < RESET_CYCLES + STIM_CYCLES; i++) begin
            @(posedge CLK);
            update_model();
            drive_random();
            // Reset drops on the last reset edge
            if (i == RESET_CYCLES - 1) begin
                rst_n <= 1'b1;
            end
            @(negedge CLK);
            check_outputs();
        end

        if (dut.u_checker.fail_count != 0) begin
            $display("checker assertions failed %0d times", dut.u_checker.fail_count);
            $display("sim failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: tb.f
logic/io_pkg.sv
logic/io_port_decoder.sv
logic/bin_to_bcd.sv
logic/seg_scanner.sv
logic/io_wrapper.sv
test/io_wrapper_checker.sv
test/io_wrapper_tb.sv
